// ==== src/nn_config.svh ====
`ifndef NN_CONFIG_SVH
`define NN_CONFIG_SVH

// ------------------------------
// fixed-point format
// ------------------------------
`define NN_DATA_W 16 // signed word width
`define NN_FRAC_BITS 8 // q8.8

// ------------------------------
// network shape
// ------------------------------
`define NN_INPUTS 4 // features per sample
`define NN_HIDDEN 3 // relu neurons

// sample slots, also the sender's starting credits
`define NN_QUEUE_DEPTH 2

`endif

// ==== src/nn_pkg.sv ====
`include "nn_config.svh"

package nn_pkg;

	// one signed q8.8 value
	typedef logic signed [`NN_DATA_W-1:0] fx_t;

	typedef fx_t [`NN_INPUTS-1:0] feature_vec_t; // feature i at slot i
	typedef fx_t [`NN_HIDDEN-1:0][`NN_INPUTS-1:0] w1_mat_t; // [neuron][input]
	typedef fx_t [`NN_HIDDEN-1:0] w2_vec_t; // one weight per hidden neuron
	typedef fx_t [`NN_HIDDEN-1:0] hidden_vec_t; // relu outputs

	localparam int FX_PROD_W = 2 * `NN_DATA_W; // full product width

	// ------------------------------
	// fixed-point multiply
	// ------------------------------
	// full signed product, arithmetic shift by the fraction bits, low word kept
	function automatic fx_t fx_mul(input fx_t a, input fx_t b);
		logic signed [FX_PROD_W-1:0] prod;
		logic signed [FX_PROD_W-1:0] scaled;
		prod = FX_PROD_W'(a) * FX_PROD_W'(b); // sign-extended operands
		scaled = prod >>> `NN_FRAC_BITS; // back to q8.8 scale
		return scaled[`NN_DATA_W-1:0]; // wraps on overflow
	endfunction

endpackage

// ==== src/sample_queue.sv ====
`include "nn_config.svh"

module sample_queue (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 sample_valid,
	input  nn_pkg::fx_t          sample_data,
	input  logic                 q_take,
	output logic                 q_valid,
	output nn_pkg::feature_vec_t q_vec,
	output logic                 credit_return
);

	localparam int DEPTH = `NN_QUEUE_DEPTH;
	localparam int BEAT_W = $clog2(`NN_INPUTS);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [BEAT_W-1:0]    beat_idx; // next feature slot
	nn_pkg::feature_vec_t asm_vec; // partial sample
	nn_pkg::feature_vec_t push_vec; // finished sample incl. last beat
	nn_pkg::feature_vec_t slot_mem [DEPTH]; // circular buffer
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CNT_W-1:0]     count; // queued vectors
	logic                 push;
	logic                 pop;

	// ------------------------------
	// beat assembly
	// ------------------------------
	assign push = sample_valid && (beat_idx == BEAT_W'(`NN_INPUTS - 1)); // fourth beat
	assign pop = q_take; // hidden layer takes the head

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_idx <= '0;
		end
		else if (sample_valid) begin
			beat_idx <= push ? '0 : beat_idx + 1'b1; // feature 0 first
		end
	end

	always_ff @(posedge clk) begin
		if (sample_valid) begin
			asm_vec[beat_idx] <= sample_data;
		end
	end

	always_comb begin
		push_vec = asm_vec;
		push_vec[`NN_INPUTS-1] = sample_data; // last beat bypasses asm_vec
	end

	// ------------------------------
	// vector buffer
	// ------------------------------
	always_ff @(posedge clk) begin
		if (push) begin
			slot_mem[wr_ptr] <= push_vec;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end
		else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // none or both
			endcase
			credit_return <= pop; // one credit back per pop
		end
	end

	assign q_valid = (count != '0); // head visible cycle after 4th beat
	assign q_vec = slot_mem[rd_ptr];

endmodule

// ==== src/weight_store.sv ====
`include "nn_config.svh"

module weight_store (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            w1_valid,
	input  nn_pkg::fx_t     w1_data,
	input  logic            w2_valid,
	input  nn_pkg::fx_t     w2_data,
	output nn_pkg::w1_mat_t w1,
	output nn_pkg::w2_vec_t w2
);

	localparam int W1_BITS = $bits(nn_pkg::w1_mat_t); // 12 words
	localparam int W2_BITS = $bits(nn_pkg::w2_vec_t); // 3 words

	logic [W1_BITS-1:0] w1_sr; // flat chain, word k = neuron k/4, input k%4
	logic [W2_BITS-1:0] w2_sr;

	// ------------------------------
	// first layer chain
	// ------------------------------
	// new word enters the top slot, older words move one slot down
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w1_sr <= '0;
		end
		else if (w1_valid) begin
			w1_sr <= {w1_data, w1_sr[W1_BITS-1:`NN_DATA_W]}; // first beat ends at slot 0
		end
	end

	// ------------------------------
	// second layer chain
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w2_sr <= '0;
		end
		else if (w2_valid) begin
			w2_sr <= {w2_data, w2_sr[W2_BITS-1:`NN_DATA_W]}; // same order, 3 beats
		end
	end

	assign w1 = w1_sr;
	assign w2 = w2_sr;

endmodule

// ==== src/hidden_layer.sv ====
`include "nn_config.svh"

module hidden_layer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 q_valid,
	input  nn_pkg::feature_vec_t q_vec,
	input  nn_pkg::w1_mat_t      w1,
	output logic                 q_take,
	output logic                 hid_valid,
	output nn_pkg::hidden_vec_t  hid_vec
);

	localparam int IDX_W = $clog2(`NN_INPUTS);

	typedef enum logic [1:0] {
		S_IDLE, // waiting for a vector
		S_ACC, // features 1..3
		S_RELU // clamp and register
	} state_t;

	state_t               state;
	logic [IDX_W-1:0]     feat_idx; // feature being accumulated
	nn_pkg::feature_vec_t feat_sr; // remaining features, next at slot 0
	nn_pkg::fx_t          feat_cur;
	nn_pkg::hidden_vec_t  prod; // per-neuron products this cycle
	nn_pkg::hidden_vec_t  acc; // per-neuron running sums

	assign q_take = (state == S_IDLE) && q_valid; // accept straight from the queue head
	assign feat_cur = (state == S_IDLE) ? q_vec[0] : feat_sr[0]; // feature 0 on accept

	always_comb begin
		for (int j = 0; j < `NN_HIDDEN; j++) begin
			prod[j] = nn_pkg::fx_mul(w1[j][feat_idx], feat_cur);
		end
	end

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			feat_idx <= '0;
		end
		else begin
			case (state)
				S_IDLE: begin
					if (q_valid) begin
						state <= S_ACC;
						feat_idx <= IDX_W'(1); // feature 0 done on accept
					end
				end
				S_ACC: begin
					if (feat_idx == IDX_W'(`NN_INPUTS - 1)) begin
						state <= S_RELU;
						feat_idx <= '0; // ready for next accept
					end
					else begin
						feat_idx <= feat_idx + 1'b1;
					end
				end
				default: state <= S_IDLE; // relu takes one cycle
			endcase
		end
	end

	// ------------------------------
	// accumulators
	// ------------------------------
	always_ff @(posedge clk) begin
		if (q_take) begin
			feat_sr <= q_vec >> `NN_DATA_W; // feature 1 moves to slot 0
			acc <= prod; // start sums with feature 0
		end
		else if (state == S_ACC) begin
			feat_sr <= feat_sr >> `NN_DATA_W;
			for (int j = 0; j < `NN_HIDDEN; j++) begin
				acc[j] <= acc[j] + prod[j]; // wraps at 16 bits
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_RELU) begin
			for (int j = 0; j < `NN_HIDDEN; j++) begin
				hid_vec[j] <= acc[j][`NN_DATA_W-1] ? '0 : acc[j]; // negative -> 0
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hid_valid <= 1'b0;
		end
		else begin
			hid_valid <= (state == S_RELU); // 5 cycles after q_take
		end
	end

endmodule

// ==== src/output_layer.sv ====
`include "nn_config.svh"

module output_layer (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                hid_valid,
	input  nn_pkg::hidden_vec_t hid_vec,
	input  nn_pkg::w2_vec_t     w2,
	output logic                out_valid,
	output nn_pkg::fx_t         out_data
);

	nn_pkg::fx_t dot; // y = sum w2[j] * h[j]

	// ------------------------------
	// output dot product
	// ------------------------------
	always_comb begin
		dot = '0;
		for (int j = 0; j < `NN_HIDDEN; j++) begin
			dot = dot + nn_pkg::fx_mul(w2[j], hid_vec[j]); // wraps at 16 bits
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data <= '0;
		end
		else begin
			out_valid <= hid_valid; // single-cycle pulse
			out_data <= hid_valid ? dot : '0; // zero between results
		end
	end

endmodule

// ==== src/nn_top.sv ====
module nn_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        w1_valid,
	input  nn_pkg::fx_t w1_data,
	input  logic        w2_valid,
	input  nn_pkg::fx_t w2_data,
	input  logic        sample_valid,
	input  nn_pkg::fx_t sample_data,
	output logic        credit_return,
	output logic        out_valid,
	output nn_pkg::fx_t out_data
);

	logic                 q_valid; // queue head present
	logic                 q_take; // head accepted by hidden layer
	logic                 hid_valid;
	nn_pkg::feature_vec_t q_vec;
	nn_pkg::w1_mat_t      w1;
	nn_pkg::w2_vec_t      w2;
	nn_pkg::hidden_vec_t  hid_vec;

	// ------------------------------
	// sample path
	// ------------------------------
	sample_queue u_queue (
		.clk           (clk),
		.rst_n         (rst_n),
		.sample_valid  (sample_valid),
		.sample_data   (sample_data),
		.q_take        (q_take),
		.q_valid       (q_valid),
		.q_vec         (q_vec),
		.credit_return (credit_return)
	);

	weight_store u_weights (
		.clk      (clk),
		.rst_n    (rst_n),
		.w1_valid (w1_valid),
		.w1_data  (w1_data),
		.w2_valid (w2_valid),
		.w2_data  (w2_data),
		.w1       (w1),
		.w2       (w2)
	);

	hidden_layer u_hidden (
		.clk       (clk),
		.rst_n     (rst_n),
		.q_valid   (q_valid),
		.q_vec     (q_vec),
		.w1        (w1),
		.q_take    (q_take),
		.hid_valid (hid_valid),
		.hid_vec   (hid_vec)
	);

	output_layer u_output (
		.clk       (clk),
		.rst_n     (rst_n),
		.hid_valid (hid_valid),
		.hid_vec   (hid_vec),
		.w2        (w2),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

// ==== dv/nn_asserts.sv ====
`include "nn_config.svh"

module nn_asserts (
	input logic                                  clk,
	input logic                                  rst_n,
	input logic                                  push,
	input logic [$clog2(`NN_QUEUE_DEPTH+1)-1:0] count,
	input logic                                  q_take,
	input logic                                  credit_return
);

	localparam int CNT_W = $clog2(`NN_QUEUE_DEPTH + 1);

	// ------------------------------
	// queue occupancy
	// ------------------------------
	push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> (count != CNT_W'(`NN_QUEUE_DEPTH)))
		else $error("sample pushed while the queue was full");

	pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
		q_take |-> (count != '0))
		else $error("vector taken while the queue was empty");

	// ------------------------------
	// credit pulses
	// ------------------------------
	credit_needs_take: assert property (@(posedge clk) disable iff (!rst_n)
		credit_return |-> $past(q_take))
		else $error("credit pulse without a take");

endmodule

// ==== dv/nn_tb.sv ====
`include "nn_config.svh"

module nn_tb;

	localparam int TIMEOUT = 200; // cycles per wait
	localparam int DEPTH = `NN_QUEUE_DEPTH;

	logic            clk;
	logic            rst_n;
	logic            w1_valid;
	logic            w2_valid;
	logic            sample_valid;
	nn_pkg::fx_t     w1_data;
	nn_pkg::fx_t     w2_data;
	nn_pkg::fx_t     sample_data;
	logic            credit_return;
	logic            out_valid;
	nn_pkg::fx_t     out_data;
	nn_pkg::w1_mat_t tb_w1; // weights the model uses
	nn_pkg::w2_vec_t tb_w2;
	nn_pkg::fx_t     exp_q[$]; // model results in send order
	nn_pkg::fx_t     got_q[$]; // dut results
	int              credits; // sender's view
	int              credits_back; // total credit pulses
	integer          seed;

	nn_top dut0 (.*);

	bind sample_queue nn_asserts u_asserts (
		.clk           (clk),
		.rst_n         (rst_n),
		.push          (push),
		.count         (count),
		.q_take        (q_take),
		.credit_return (credit_return)
	);

	always #10 clk = ~clk;

	always @(negedge clk) begin // outputs are stable here
		if (rst_n) begin
			if (out_valid) got_q.push_back(out_data);
			if (credit_return) begin
				credits++;
				credits_back++;
			end
		end
	end

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic nn_pkg::fx_t qmul(input nn_pkg::fx_t a, input nn_pkg::fx_t b);
		int p;
		p = int'(a) * int'(b); // exact in 32 bits
		return nn_pkg::fx_t'(p >>> `NN_FRAC_BITS);
	endfunction

	function automatic nn_pkg::fx_t model_out(input nn_pkg::feature_vec_t x);
		nn_pkg::fx_t h;
		nn_pkg::fx_t y;
		y = '0;
		for (int j = 0; j < `NN_HIDDEN; j++) begin
			h = '0;
			for (int i = 0; i < `NN_INPUTS; i++) h = h + qmul(tb_w1[j][i], x[i]);
			if (h < 0) h = '0; // relu
			y = y + qmul(tb_w2[j], h);
		end
		return y;
	endfunction

	// ------------------------------
	// checks and drivers
	// ------------------------------
	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_fx(input string name, input nn_pkg::fx_t exp, input nn_pkg::fx_t act);
		if (act !== exp)
			report_fail($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			report_fail($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2; // drive phase
	endtask

	task automatic load_weights();
		for (int k = 0; k < `NN_HIDDEN * `NN_INPUTS; k++) begin
			w1_valid = 1'b1;
			w1_data = tb_w1[k / `NN_INPUTS][k % `NN_INPUTS]; // beat k -> neuron k/4
			next_cycle();
		end
		w1_valid = 1'b0;
		for (int k = 0; k < `NN_HIDDEN; k++) begin
			w2_valid = 1'b1;
			w2_data = tb_w2[k];
			next_cycle();
		end
		w2_valid = 1'b0;
	endtask

	task automatic send_sample(input nn_pkg::feature_vec_t x);
		int waited;
		waited = 0;
		while (credits == 0) begin // sender holds until a credit is back
			next_cycle();
			waited++;
			if (waited > TIMEOUT) report_fail("no credit came back to the sender");
		end
		credits--;
		exp_q.push_back(model_out(x));
		for (int i = 0; i < `NN_INPUTS; i++) begin
			sample_valid = 1'b1;
			sample_data = x[i]; // feature 0 first
			next_cycle();
		end
		sample_valid = 1'b0;
	endtask

	task automatic drain_results(input string name);
		int waited;
		waited = 0;
		while (got_q.size() < exp_q.size() || credits != DEPTH) begin
			next_cycle();
			waited++;
			if (waited > TIMEOUT) report_fail({name, ": results or credits did not arrive"});
		end
		repeat (8) next_cycle(); // room for stray results
		check_count({name, " results"}, exp_q.size(), got_q.size());
		while (exp_q.size() > 0) check_fx(name, exp_q.pop_front(), got_q.pop_front());
		check_count({name, " credits"}, DEPTH, credits);
	endtask

	function automatic nn_pkg::feature_vec_t make_vec(input int a, input int b,
		input int c, input int d);
		nn_pkg::feature_vec_t x;
		x[0] = nn_pkg::fx_t'(a);
		x[1] = nn_pkg::fx_t'(b);
		x[2] = nn_pkg::fx_t'(c);
		x[3] = nn_pkg::fx_t'(d);
		return x;
	endfunction

	task automatic ramp_weights(input int sign1, input int sign2);
		for (int j = 0; j < `NN_HIDDEN; j++) begin
			for (int i = 0; i < `NN_INPUTS; i++) begin
				tb_w1[j][i] = nn_pkg::fx_t'(32 * (i + 1) + 64 * j); // 0.125 .. 1.0
			end
			tb_w2[j] = nn_pkg::fx_t'(128 + 64 * j);
		end
		for (int i = 0; i < `NN_INPUTS; i++) begin
			tb_w1[1][i] = nn_pkg::fx_t'(sign1 * int'(tb_w1[1][i])); // neuron 1 flipped
			tb_w1[2][i] = nn_pkg::fx_t'(sign2 * int'(tb_w1[2][i]));
		end
		load_weights();
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic reset_idle();
		repeat (5) begin
			@(negedge clk);
			check_fx("reset out_data", '0, out_data);
		end
		next_cycle();
		check_count("reset results", 0, got_q.size());
		check_count("reset credit pulses", 0, credits_back);
	endtask

	task automatic single_sample();
		ramp_weights(1, 1);
		send_sample(make_vec(256, 512, -128, 384)); // 1.0 2.0 -0.5 1.5
		drain_results("single");
	endtask

	task automatic negative_hidden();
		ramp_weights(-1, -1); // neurons 1 and 2 go negative
		send_sample(make_vec(256, 128, 64, 512));
		drain_results("relu");
	endtask

	task automatic back_to_back();
		ramp_weights(1, -1);
		send_sample(make_vec(100, -200, 300, 50));
		send_sample(make_vec(-60, 700, 20, 256));
		drain_results("back to back");
	endtask

	task automatic random_stream();
		nn_pkg::feature_vec_t x;
		int gap;
		for (int j = 0; j < `NN_HIDDEN; j++) begin
			for (int i = 0; i < `NN_INPUTS; i++) tb_w1[j][i] = nn_pkg::fx_t'($random(seed));
			tb_w2[j] = nn_pkg::fx_t'($random(seed));
		end
		load_weights();
		for (int n = 0; n < 20; n++) begin
			for (int i = 0; i < `NN_INPUTS; i++) x[i] = nn_pkg::fx_t'($random(seed));
			send_sample(x);
			gap = $random(seed) & 3; // idle 0..3 cycles
			repeat (gap) next_cycle();
		end
		drain_results("random stream");
	endtask

	task automatic weight_reload();
		nn_pkg::feature_vec_t x;
		x = make_vec(300, -100, 200, 400);
		ramp_weights(1, 1);
		send_sample(x);
		drain_results("reload first");
		ramp_weights(-1, 1);
		send_sample(x); // same sample, new weights
		drain_results("reload second");
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		w1_valid = 1'b0;
		w2_valid = 1'b0;
		sample_valid = 1'b0;
		w1_data = '0;
		w2_data = '0;
		sample_data = '0;
		credits = DEPTH;
		credits_back = 0;
		seed = 99681;
		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
		reset_idle();
		single_sample();
		negative_hidden();
		back_to_back();
		random_stream();
		weight_reload();
		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== nn_top.f ====
+incdir+src
src/nn_pkg.sv
src/sample_queue.sv
src/weight_store.sv
src/hidden_layer.sv
src/output_layer.sv
src/nn_top.sv
dv/nn_asserts.sv
dv/nn_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= nn_tb
RTL_TOP   ?= nn_top
FILELIST  ?= nn_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
